//--- list.f
hdl/rsPkg.sv
hdl/operandCapture.sv
hdl/stationEntries.sv
hdl/dispatchSelect.sv
hdl/dpStation.sv
tests/dpStationChecks.sv
tests/dpStationTb.sv

//--- tests/dpStationTb.sv
`timescale 1ns/100ps

module dpStationTb;
    import rsPkg::*;

    localparam int timeoutLimit = 100;

    logic CLK, Reset, issueValid, issueReady, regWrite, noWrite, useImm;
    logic src1Busy, src2Busy, flagsReady, aluResultValid, memResultValid, flagResultValid;
    logic dispatchValid, dispatchReady, dispatchRegWrite, dispatchNoWrite, dispatchUseImm;
    logic [opWidth-1:0] opcode, dispatchOp;
    logic [condWidth-1:0] cond, dispatchCond;
    logic [flagWriteWidth-1:0] flagWrite, dispatchFlagWrite;
    logic [shamtWidth-1:0] shamt, dispatchShamt;
    logic [shiftTypeWidth-1:0] shiftType, dispatchShiftType;
    logic [dataWidth-1:0] immediate, regData1, regData2, aluResult, memResult;
    logic [dataWidth-1:0] dispatchSrcA, dispatchSrcB;
    logic [robIndexWidth-1:0] robTail, src1Tag, src2Tag, flagsTag, aluResultTag;
    logic [robIndexWidth-1:0] memResultTag, flagResultTag, dispatchRobIndex;
    int checkErrors;
    int tbErrors = 0;
    int timeouts = 0;

    dpStation #(.stationDepth(2)) dpStation_inst (.*);

    dpStationChecks dpStationChecks_inst (.*, .errorCount(checkErrors));

    initial begin
        CLK = 1'b0;
        forever #2 CLK = ~CLK;
    end

    task automatic reportMismatch(input string msg);
        tbErrors++;
        $display("CHECK FAILED at %0t: %s", $time, msg);
    endtask

    task automatic nextCycle();
        @(negedge CLK);
        issueValid = 1'b0;
        aluResultValid = 1'b0;
        memResultValid = 1'b0;
        flagResultValid = 1'b0;
    endtask

    // Drives one instruction; the caller advances the clock.
    task automatic issue(input logic [robIndexWidth-1:0] rob, input logic imm,
            input logic busy1, input logic [robIndexWidth-1:0] tag1, input logic busy2,
            input logic [robIndexWidth-1:0] tag2, input logic [condWidth-1:0] c,
            input logic fReady, input logic [robIndexWidth-1:0] fTag);
        int n = 0;
        while (!issueReady && n < timeoutLimit) begin
            @(negedge CLK);
            n++;
        end
        if (!issueReady) begin
            timeouts++;
            $display("Timed out waiting for the station to accept rob %0d.", rob);
        end
        opcode = $urandom;
        flagWrite = $urandom;
        regWrite = $urandom;
        noWrite = $urandom;
        shamt = $urandom;
        shiftType = $urandom;
        immediate = $urandom;
        regData1 = $urandom;
        regData2 = $urandom;
        {useImm, robTail, cond, flagsReady, flagsTag} = {imm, rob, c, fReady, fTag};
        {src1Busy, src1Tag, src2Busy, src2Tag} = {busy1, tag1, busy2, tag2};
        issueValid = 1'b1;
    endtask

    task automatic waitDispatch();
        int n = 0;
        while (!dispatchValid && n < timeoutLimit) begin
            nextCycle();
            n++;
        end
        if (!dispatchValid) begin
            timeouts++;
            $display("Timed out waiting for a dispatch.");
        end
    endtask

    // Takes the dispatch and frees its entry through the ALU lane.
    task automatic takeDispatch(input logic [robIndexWidth-1:0] rob);
        waitDispatch();
        assert (dispatchRobIndex == rob) else reportMismatch("unexpected dispatch order");
        dispatchReady = 1'b1;
        aluResultValid = 1'b1;
        aluResultTag = rob;
        aluResult = $urandom;
        nextCycle();
    endtask

    task automatic expectIdle(input int cycles);
        repeat (cycles) begin
            assert (!dispatchValid) else reportMismatch("dispatch while a source is waiting");
            nextCycle();
        end
    endtask

    initial begin
        int n;
        void'($urandom(32'h748a_61bb));
        {issueValid, regWrite, noWrite, useImm, src1Busy, src2Busy, flagsReady} = '0;
        {aluResultValid, memResultValid, flagResultValid} = '0;
        {opcode, flagWrite, shamt, shiftType, immediate, regData1, regData2} = '0;
        {aluResult, memResult, robTail, src1Tag, src2Tag, flagsTag} = '0;
        {aluResultTag, memResultTag, flagResultTag} = '0;
        cond = condAlways;
        dispatchReady = 1'b1;
        Reset = 1'b1;
        repeat (5) @(posedge CLK);
        @(negedge CLK);
        Reset = 1'b0;

        issue(0, 0, 0, 0, 0, 0, condAlways, 0, 0);     // Ready sources from the register file.
        nextCycle();
        takeDispatch(0);
        issue(1, 1, 0, 0, 0, 0, condAlways, 0, 0);
        nextCycle();
        takeDispatch(1);

        issue(2, 0, 1, 5, 0, 0, condAlways, 1, 0);     // Wakes on the ALU lane.
        nextCycle();
        expectIdle(3);
        {aluResultValid, aluResultTag, aluResult} = {1'b1, 3'd5, 32'($urandom)};
        nextCycle();
        takeDispatch(2);
        issue(3, 0, 0, 0, 1, 6, condAlways, 1, 0);     // Wakes on the memory lane.
        nextCycle();
        expectIdle(2);
        {memResultValid, memResultTag, memResult} = {1'b1, 3'd6, 32'($urandom)};
        nextCycle();
        takeDispatch(3);

        issue(0, 0, 1, 7, 1, 6, condAlways, 1, 0);
        {aluResultValid, aluResultTag, aluResult} = {1'b1, 3'd7, 32'($urandom)};
        {memResultValid, memResultTag, memResult} = {1'b1, 3'd6, 32'($urandom)};
        nextCycle();
        takeDispatch(0);

        issue(1, 0, 0, 0, 0, 0, 4'h0, 0, 4);           // Needs the flag broadcast.
        nextCycle();
        expectIdle(3);
        {flagResultValid, flagResultTag} = {1'b1, 3'd4};
        nextCycle();
        takeDispatch(1);
        issue(2, 0, 0, 0, 0, 0, condAlways, 0, 4);
        nextCycle();
        takeDispatch(2);

        dispatchReady = 1'b0;
        issue(0, 0, 1, 5, 0, 0, condAlways, 1, 0);
        nextCycle();
        issue(1, 0, 1, 5, 0, 0, condAlways, 1, 0);
        nextCycle();
        assert (!issueReady) else reportMismatch("issueReady high with every entry taken");
        {aluResultValid, aluResultTag, aluResult} = {1'b1, 3'd5, 32'($urandom)};
        nextCycle();
        waitDispatch();
        repeat ($urandom_range(5, 2)) nextCycle();
        takeDispatch(0);
        n = 0;
        while (!issueReady && n < timeoutLimit) begin
            nextCycle();
            n++;
        end
        if (!issueReady) begin
            timeouts++;
            $display("issueReady never returned after the entry was released.");
        end
        takeDispatch(1);
        repeat (4) nextCycle();

        $display("Errors: %0d, timeouts: %0d", tbErrors + checkErrors, timeouts);
        if (tbErrors + checkErrors + timeouts == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end
endmodule

//--- tests/dpStationChecks.sv
`timescale 1ns/100ps

module dpStationChecks (
    input  logic                             CLK,
    input  logic                             Reset,
    input  logic                             issueValid,
    input  logic                             issueReady,
    input  logic [rsPkg::opWidth-1:0]        opcode,
    input  logic [rsPkg::condWidth-1:0]      cond,
    input  logic [rsPkg::flagWriteWidth-1:0] flagWrite,
    input  logic                             regWrite,
    input  logic                             noWrite,
    input  logic [rsPkg::shamtWidth-1:0]     shamt,
    input  logic [rsPkg::shiftTypeWidth-1:0] shiftType,
    input  logic                             useImm,
    input  logic [rsPkg::dataWidth-1:0]      immediate,
    input  logic [rsPkg::robIndexWidth-1:0]  robTail,
    input  logic [rsPkg::dataWidth-1:0]      regData1,
    input  logic [rsPkg::dataWidth-1:0]      regData2,
    input  logic                             src1Busy,
    input  logic [rsPkg::robIndexWidth-1:0]  src1Tag,
    input  logic                             src2Busy,
    input  logic [rsPkg::robIndexWidth-1:0]  src2Tag,
    input  logic                             flagsReady,
    input  logic [rsPkg::robIndexWidth-1:0]  flagsTag,
    input  logic                             aluResultValid,
    input  logic [rsPkg::robIndexWidth-1:0]  aluResultTag,
    input  logic [rsPkg::dataWidth-1:0]      aluResult,
    input  logic                             memResultValid,
    input  logic [rsPkg::robIndexWidth-1:0]  memResultTag,
    input  logic [rsPkg::dataWidth-1:0]      memResult,
    input  logic                             flagResultValid,
    input  logic [rsPkg::robIndexWidth-1:0]  flagResultTag,
    input  logic                             dispatchValid,
    input  logic                             dispatchReady,
    input  logic [rsPkg::opWidth-1:0]        dispatchOp,
    input  logic [rsPkg::condWidth-1:0]      dispatchCond,
    input  logic [rsPkg::flagWriteWidth-1:0] dispatchFlagWrite,
    input  logic                             dispatchRegWrite,
    input  logic                             dispatchNoWrite,
    input  logic [rsPkg::shamtWidth-1:0]     dispatchShamt,
    input  logic [rsPkg::shiftTypeWidth-1:0] dispatchShiftType,
    input  logic [rsPkg::dataWidth-1:0]      dispatchSrcA,
    input  logic [rsPkg::dataWidth-1:0]      dispatchSrcB,
    input  logic                             dispatchUseImm,
    input  logic [rsPkg::robIndexWidth-1:0]  dispatchRobIndex,
    output int                               errorCount
);
    import rsPkg::*;

    localparam int robSize = 2 ** robIndexWidth;

    logic [dataWidth-1:0] expA [robSize];
    logic [dataWidth-1:0] expB [robSize];
    logic [robIndexWidth-1:0] tagA [robSize];
    logic [robIndexWidth-1:0] tagB [robSize];
    logic [robIndexWidth-1:0] tagF [robSize];
    logic [opWidth-1:0] expOp [robSize];
    logic [condWidth-1:0] expCond [robSize];
    logic [flagWriteWidth-1:0] expFlagWrite [robSize];
    logic [shamtWidth-1:0] expShamt [robSize];
    logic [shiftTypeWidth-1:0] expShiftType [robSize];
    logic [robSize-1:0] expRegWrite;
    logic [robSize-1:0] expNoWrite;
    logic [robSize-1:0] pendA;
    logic [robSize-1:0] pendB;
    logic [robSize-1:0] pendF;
    logic [robSize-1:0] issued = '0;
    logic [robSize-1:0] immUsed;

    initial errorCount = 0;

    // Returns {waiting, value} for a register source seen at issue.
    function automatic logic [dataWidth:0] sourceAtIssue(input logic busy,
            input logic [robIndexWidth-1:0] tag, input logic [dataWidth-1:0] value);
        if (busy && aluResultValid && aluResultTag == tag) return {1'b0, aluResult};
        if (busy && memResultValid && memResultTag == tag) return {1'b0, memResult};
        return {busy, value};
    endfunction

    always @(posedge CLK) begin
        for (int r = 0; r < robSize; r++) begin
            if (pendA[r] && aluResultValid && aluResultTag == tagA[r]) begin
                expA[r] <= aluResult;
                pendA[r] <= 1'b0;
            end else if (pendA[r] && memResultValid && memResultTag == tagA[r]) begin
                expA[r] <= memResult;
                pendA[r] <= 1'b0;
            end
            if (pendB[r] && aluResultValid && aluResultTag == tagB[r]) begin
                expB[r] <= aluResult;
                pendB[r] <= 1'b0;
            end else if (pendB[r] && memResultValid && memResultTag == tagB[r]) begin
                expB[r] <= memResult;
                pendB[r] <= 1'b0;
            end
            if (pendF[r] && flagResultValid && flagResultTag == tagF[r]) begin
                pendF[r] <= 1'b0;
            end
        end
        if (!Reset && issueValid && issueReady) begin   // Issue overrides wake-up of a reused index.
            {pendA[robTail], expA[robTail]} <= sourceAtIssue(src1Busy, src1Tag, regData1);
            if (useImm) begin
                {pendB[robTail], expB[robTail]} <= {1'b0, immediate};
            end else begin
                {pendB[robTail], expB[robTail]} <= sourceAtIssue(src2Busy, src2Tag, regData2);
            end
            pendF[robTail] <= (cond != condAlways) && !flagsReady;
            tagA[robTail] <= src1Tag;
            tagB[robTail] <= src2Tag;
            tagF[robTail] <= flagsTag;
            expOp[robTail] <= opcode;
            expCond[robTail] <= cond;
            expFlagWrite[robTail] <= flagWrite;
            expRegWrite[robTail] <= regWrite;
            expNoWrite[robTail] <= noWrite;
            expShamt[robTail] <= shamt;
            expShiftType[robTail] <= shiftType;
            immUsed[robTail] <= useImm;
            issued[robTail] <= 1'b1;
        end
    end

    assert property (@(posedge CLK) disable iff (Reset) dispatchValid |->
            issued[dispatchRobIndex] && !pendA[dispatchRobIndex]
            && !pendB[dispatchRobIndex] && !pendF[dispatchRobIndex])
        else begin
            errorCount++;
            $display("CHECK FAILED at %0t: dispatch of rob %0d before its sources were ready",
                $time, dispatchRobIndex);
        end

    assert property (@(posedge CLK) disable iff (Reset) dispatchValid && dispatchReady |->
            dispatchSrcA == expA[dispatchRobIndex] && dispatchSrcB == expB[dispatchRobIndex])
        else begin
            errorCount++;
            $display("CHECK FAILED at %0t: wrong operand values for rob %0d",
                $time, dispatchRobIndex);
        end

    assert property (@(posedge CLK) disable iff (Reset) dispatchValid && dispatchReady |->
            dispatchOp == expOp[dispatchRobIndex] && dispatchCond == expCond[dispatchRobIndex]
            && dispatchUseImm == immUsed[dispatchRobIndex]
            && dispatchFlagWrite == expFlagWrite[dispatchRobIndex]
            && dispatchRegWrite == expRegWrite[dispatchRobIndex]
            && dispatchNoWrite == expNoWrite[dispatchRobIndex]
            && dispatchShamt == expShamt[dispatchRobIndex]
            && dispatchShiftType == expShiftType[dispatchRobIndex])
        else begin
            errorCount++;
            $display("CHECK FAILED at %0t: wrong control fields for rob %0d",
                $time, dispatchRobIndex);
        end

    assert property (@(posedge CLK) disable iff (Reset) dispatchValid && !dispatchReady |=>
            dispatchValid && $stable(dispatchRobIndex) && $stable(dispatchSrcA)
            && $stable(dispatchSrcB) && $stable(dispatchOp) && $stable(dispatchCond)
            && $stable(dispatchFlagWrite) && $stable(dispatchRegWrite)
            && $stable(dispatchNoWrite) && $stable(dispatchShamt)
            && $stable(dispatchShiftType) && $stable(dispatchUseImm))
        else begin
            errorCount++;
            $display("CHECK FAILED at %0t: dispatch payload moved during a stall", $time);
        end
endmodule

//--- hdl/dpStation.sv
`timescale 1ns/100ps

module dpStation #(
    parameter int stationDepth = 2
) (
    input  logic                             CLK,
    input  logic                             Reset,
    input  logic                             issueValid,
    output logic                             issueReady,
    input  logic [rsPkg::opWidth-1:0]        opcode,
    input  logic [rsPkg::condWidth-1:0]      cond,
    input  logic [rsPkg::flagWriteWidth-1:0] flagWrite,
    input  logic                             regWrite,
    input  logic                             noWrite,
    input  logic [rsPkg::shamtWidth-1:0]     shamt,
    input  logic [rsPkg::shiftTypeWidth-1:0] shiftType,
    input  logic                             useImm,
    input  logic [rsPkg::dataWidth-1:0]      immediate,
    input  logic [rsPkg::robIndexWidth-1:0]  robTail,
    input  logic [rsPkg::dataWidth-1:0]      regData1,
    input  logic [rsPkg::dataWidth-1:0]      regData2,
    input  logic                             src1Busy,
    input  logic [rsPkg::robIndexWidth-1:0]  src1Tag,
    input  logic                             src2Busy,
    input  logic [rsPkg::robIndexWidth-1:0]  src2Tag,
    input  logic                             flagsReady,
    input  logic [rsPkg::robIndexWidth-1:0]  flagsTag,
    input  logic                             aluResultValid,
    input  logic [rsPkg::robIndexWidth-1:0]  aluResultTag,
    input  logic [rsPkg::dataWidth-1:0]      aluResult,
    input  logic                             memResultValid,
    input  logic [rsPkg::robIndexWidth-1:0]  memResultTag,
    input  logic [rsPkg::dataWidth-1:0]      memResult,
    input  logic                             flagResultValid,
    input  logic [rsPkg::robIndexWidth-1:0]  flagResultTag,
    output logic                             dispatchValid,
    input  logic                             dispatchReady,
    output logic [rsPkg::opWidth-1:0]        dispatchOp,
    output logic [rsPkg::condWidth-1:0]      dispatchCond,
    output logic [rsPkg::flagWriteWidth-1:0] dispatchFlagWrite,
    output logic                             dispatchRegWrite,
    output logic                             dispatchNoWrite,
    output logic [rsPkg::shamtWidth-1:0]     dispatchShamt,
    output logic [rsPkg::shiftTypeWidth-1:0] dispatchShiftType,
    output logic [rsPkg::dataWidth-1:0]      dispatchSrcA,
    output logic [rsPkg::dataWidth-1:0]      dispatchSrcB,
    output logic                             dispatchUseImm,
    output logic [rsPkg::robIndexWidth-1:0]  dispatchRobIndex
);
    import rsPkg::*;

    logic                     allocate;
    logic                     full;
    logic [dataWidth-1:0]     srcAValue;
    logic                     srcAPending;
    logic [robIndexWidth-1:0] srcATag;
    logic [dataWidth-1:0]     srcBValue;
    logic                     srcBPending;
    logic [robIndexWidth-1:0] srcBTag;
    logic                     flagPending;
    logic [robIndexWidth-1:0] flagTag;
    logic [stationDepth-1:0]  entryReady;
    logic [stationDepth-1:0]  pick;
    logic [stationDepth-1:0][opWidth-1:0]        entryOp;
    logic [stationDepth-1:0][condWidth-1:0]      entryCond;
    logic [stationDepth-1:0][flagWriteWidth-1:0] entryFlagWrite;
    logic [stationDepth-1:0]                     entryRegWrite;
    logic [stationDepth-1:0]                     entryNoWrite;
    logic [stationDepth-1:0][shamtWidth-1:0]     entryShamt;
    logic [stationDepth-1:0][shiftTypeWidth-1:0] entryShiftType;
    logic [stationDepth-1:0][dataWidth-1:0]      entrySrcA;
    logic [stationDepth-1:0][dataWidth-1:0]      entrySrcB;
    logic [stationDepth-1:0]                     entryUseImm;
    logic [stationDepth-1:0][robIndexWidth-1:0]  entryRobIndex;

    assign issueReady = ~full;
    assign allocate = issueValid & issueReady;

    // Port names match the nets here, so the instances connect by name.
    operandCapture operandCapture_inst (.*);

    stationEntries #(
        .stationDepth(stationDepth)
    ) stationEntries_inst (.*);

    dispatchSelect #(
        .stationDepth(stationDepth)
    ) dispatchSelect_inst (.*);
endmodule

//--- hdl/dispatchSelect.sv
`timescale 1ns/100ps

module dispatchSelect #(
    parameter int stationDepth = 2
) (
    input  logic                   CLK,
    input  logic                   Reset,
    input  logic [stationDepth-1:0] entryReady,
    input  logic [stationDepth-1:0][rsPkg::opWidth-1:0]        entryOp,
    input  logic [stationDepth-1:0][rsPkg::condWidth-1:0]      entryCond,
    input  logic [stationDepth-1:0][rsPkg::flagWriteWidth-1:0] entryFlagWrite,
    input  logic [stationDepth-1:0]                            entryRegWrite,
    input  logic [stationDepth-1:0]                            entryNoWrite,
    input  logic [stationDepth-1:0][rsPkg::shamtWidth-1:0]     entryShamt,
    input  logic [stationDepth-1:0][rsPkg::shiftTypeWidth-1:0] entryShiftType,
    input  logic [stationDepth-1:0][rsPkg::dataWidth-1:0]      entrySrcA,
    input  logic [stationDepth-1:0][rsPkg::dataWidth-1:0]      entrySrcB,
    input  logic [stationDepth-1:0]                            entryUseImm,
    input  logic [stationDepth-1:0][rsPkg::robIndexWidth-1:0]  entryRobIndex,
    input  logic                   dispatchReady,
    output logic [stationDepth-1:0] pick,
    output logic                   dispatchValid,
    output logic [rsPkg::opWidth-1:0]        dispatchOp,
    output logic [rsPkg::condWidth-1:0]      dispatchCond,
    output logic [rsPkg::flagWriteWidth-1:0] dispatchFlagWrite,
    output logic                             dispatchRegWrite,
    output logic                             dispatchNoWrite,
    output logic [rsPkg::shamtWidth-1:0]     dispatchShamt,
    output logic [rsPkg::shiftTypeWidth-1:0] dispatchShiftType,
    output logic [rsPkg::dataWidth-1:0]      dispatchSrcA,
    output logic [rsPkg::dataWidth-1:0]      dispatchSrcB,
    output logic                             dispatchUseImm,
    output logic [rsPkg::robIndexWidth-1:0]  dispatchRobIndex
);
    localparam int indexWidth = (stationDepth > 1) ? $clog2(stationDepth) : 1;

    logic [indexWidth-1:0] selIndex;
    logic load;

    // The register takes a new entry when empty or draining this cycle.
    assign load = (entryReady != '0) && (!dispatchValid || dispatchReady);
    assign pick = load ? (entryReady & (~entryReady + 1'b1)) : '0;

    always_comb begin
        selIndex = '0;
        for (int i = stationDepth - 1; i >= 0; i--) begin
            if (entryReady[i]) begin
                selIndex = indexWidth'(i);
            end
        end
    end

    always_ff @(posedge CLK or posedge Reset) begin
        if (Reset) begin
            dispatchValid <= 1'b0;
        end else if (load) begin
            dispatchValid <= 1'b1;
        end else if (dispatchReady) begin
            dispatchValid <= 1'b0;
        end
    end

    always_ff @(posedge CLK) begin
        if (load) begin
            dispatchOp <= entryOp[selIndex];
            dispatchCond <= entryCond[selIndex];
            dispatchFlagWrite <= entryFlagWrite[selIndex];
            dispatchRegWrite <= entryRegWrite[selIndex];
            dispatchNoWrite <= entryNoWrite[selIndex];
            dispatchShamt <= entryShamt[selIndex];
            dispatchShiftType <= entryShiftType[selIndex];
            dispatchSrcA <= entrySrcA[selIndex];
            dispatchSrcB <= entrySrcB[selIndex];
            dispatchUseImm <= entryUseImm[selIndex];
            dispatchRobIndex <= entryRobIndex[selIndex];
        end
    end

    assert property (@(posedge CLK) disable iff (Reset)
        $onehot0(pick) && (load == pick[selIndex]))
        else $error("Pick is not one-hot or does not match the loaded entry.");

    assert property (@(posedge CLK) disable iff (Reset)
        dispatchValid && !dispatchReady |=> dispatchValid && $stable(dispatchRobIndex)
            && $stable(dispatchOp) && $stable(dispatchCond) && $stable(dispatchSrcA)
            && $stable(dispatchSrcB) && $stable(dispatchUseImm))
        else $error("Dispatch payload changed while stalled.");
endmodule

//--- hdl/stationEntries.sv
`timescale 1ns/100ps

module stationEntries #(
    parameter int stationDepth = 2
) (
    input  logic                            CLK,
    input  logic                            Reset,
    input  logic                            allocate,
    input  logic [rsPkg::dataWidth-1:0]     srcAValue,
    input  logic                            srcAPending,
    input  logic [rsPkg::robIndexWidth-1:0] srcATag,
    input  logic [rsPkg::dataWidth-1:0]     srcBValue,
    input  logic                            srcBPending,
    input  logic [rsPkg::robIndexWidth-1:0] srcBTag,
    input  logic                            flagPending,
    input  logic [rsPkg::robIndexWidth-1:0] flagTag,
    input  logic [rsPkg::opWidth-1:0]       opcode,
    input  logic [rsPkg::condWidth-1:0]     cond,
    input  logic [rsPkg::flagWriteWidth-1:0] flagWrite,
    input  logic                            regWrite,
    input  logic                            noWrite,
    input  logic [rsPkg::shamtWidth-1:0]    shamt,
    input  logic [rsPkg::shiftTypeWidth-1:0] shiftType,
    input  logic                            useImm,
    input  logic [rsPkg::robIndexWidth-1:0] robTail,
    input  logic                            aluResultValid,
    input  logic [rsPkg::robIndexWidth-1:0] aluResultTag,
    input  logic [rsPkg::dataWidth-1:0]     aluResult,
    input  logic                            memResultValid,
    input  logic [rsPkg::robIndexWidth-1:0] memResultTag,
    input  logic [rsPkg::dataWidth-1:0]     memResult,
    input  logic                            flagResultValid,
    input  logic [rsPkg::robIndexWidth-1:0] flagResultTag,
    input  logic [stationDepth-1:0]         pick,
    output logic                            full,
    output logic [stationDepth-1:0]         entryReady,
    output logic [stationDepth-1:0][rsPkg::opWidth-1:0]        entryOp,
    output logic [stationDepth-1:0][rsPkg::condWidth-1:0]      entryCond,
    output logic [stationDepth-1:0][rsPkg::flagWriteWidth-1:0] entryFlagWrite,
    output logic [stationDepth-1:0]                            entryRegWrite,
    output logic [stationDepth-1:0]                            entryNoWrite,
    output logic [stationDepth-1:0][rsPkg::shamtWidth-1:0]     entryShamt,
    output logic [stationDepth-1:0][rsPkg::shiftTypeWidth-1:0] entryShiftType,
    output logic [stationDepth-1:0][rsPkg::dataWidth-1:0]      entrySrcA,
    output logic [stationDepth-1:0][rsPkg::dataWidth-1:0]      entrySrcB,
    output logic [stationDepth-1:0]                            entryUseImm,
    output logic [stationDepth-1:0][rsPkg::robIndexWidth-1:0]  entryRobIndex
);
    import rsPkg::*;

    logic [stationDepth-1:0] occupied;
    logic [stationDepth-1:0] picked;
    logic [stationDepth-1:0] pendA;
    logic [stationDepth-1:0] pendB;
    logic [stationDepth-1:0] pendF;
    logic [stationDepth-1:0][robIndexWidth-1:0] tagA;
    logic [stationDepth-1:0][robIndexWidth-1:0] tagB;
    logic [stationDepth-1:0][robIndexWidth-1:0] tagF;
    logic [stationDepth-1:0] allocSel;
    logic [stationDepth-1:0] allocWrite;
    logic [stationDepth-1:0] aAlu;
    logic [stationDepth-1:0] aMem;
    logic [stationDepth-1:0] bAlu;
    logic [stationDepth-1:0] bMem;
    logic [stationDepth-1:0] fHit;
    logic [stationDepth-1:0] freeing;

    assign full = &occupied;
    assign allocSel = ~occupied & (occupied + 1'b1);      // Lowest free entry.
    assign allocWrite = allocate ? allocSel : '0;
    assign entryReady = occupied & ~picked & ~pendA & ~pendB & ~pendF;

    always_comb begin
        for (int i = 0; i < stationDepth; i++) begin
            aAlu[i] = pendA[i] && aluResultValid && aluResultTag == tagA[i];
            aMem[i] = pendA[i] && memResultValid && memResultTag == tagA[i];
            bAlu[i] = pendB[i] && aluResultValid && aluResultTag == tagB[i];
            bMem[i] = pendB[i] && memResultValid && memResultTag == tagB[i];
            fHit[i] = pendF[i] && flagResultValid && flagResultTag == tagF[i];
            freeing[i] = occupied[i] && aluResultValid && aluResultTag == entryRobIndex[i];
        end
    end

    always_ff @(posedge CLK or posedge Reset) begin
        if (Reset) begin
            occupied <= '0;
            picked <= '0;
            pendA <= '0;
            pendB <= '0;
            pendF <= '0;
        end else begin
            for (int i = 0; i < stationDepth; i++) begin
                if (allocWrite[i]) begin
                    occupied[i] <= 1'b1;
                    picked[i] <= 1'b0;
                    pendA[i] <= srcAPending;
                    pendB[i] <= srcBPending;
                    pendF[i] <= flagPending;
                end else begin
                    if (freeing[i]) begin
                        occupied[i] <= 1'b0;
                    end
                    if (pick[i]) begin
                        picked[i] <= 1'b1;
                    end
                    if (aAlu[i] || aMem[i]) begin
                        pendA[i] <= 1'b0;
                    end
                    if (bAlu[i] || bMem[i]) begin
                        pendB[i] <= 1'b0;
                    end
                    if (fHit[i]) begin
                        pendF[i] <= 1'b0;
                    end
                end
            end
        end
    end

    always_ff @(posedge CLK) begin
        for (int i = 0; i < stationDepth; i++) begin
            if (allocWrite[i]) begin
                entryOp[i] <= opcode;
                entryCond[i] <= cond;
                entryFlagWrite[i] <= flagWrite;
                entryRegWrite[i] <= regWrite;
                entryNoWrite[i] <= noWrite;
                entryShamt[i] <= shamt;
                entryShiftType[i] <= shiftType;
                entryUseImm[i] <= useImm;
                entryRobIndex[i] <= robTail;
                entrySrcA[i] <= srcAValue;
                entrySrcB[i] <= srcBValue;
                tagA[i] <= srcATag;
                tagB[i] <= srcBTag;
                tagF[i] <= flagTag;
            end else begin
                if (aAlu[i]) begin
                    entrySrcA[i] <= aluResult;
                end else if (aMem[i]) begin
                    entrySrcA[i] <= memResult;
                end
                if (bAlu[i]) begin
                    entrySrcB[i] <= aluResult;
                end else if (bMem[i]) begin
                    entrySrcB[i] <= memResult;
                end
            end
        end
    end

    assert property (@(posedge CLK) disable iff (Reset) allocate |-> !full)
        else $error("Allocation while the station is full.");

    // The ALU only broadcasts an index after the entry has gone out.
    assert property (@(posedge CLK) disable iff (Reset) (freeing & ~picked) == '0)
        else $error("Entry released before it was picked.");
endmodule

//--- hdl/operandCapture.sv
`timescale 1ns/100ps

module operandCapture (
    input  logic                            useImm,
    input  logic [rsPkg::dataWidth-1:0]     immediate,
    input  logic [rsPkg::dataWidth-1:0]     regData1,
    input  logic [rsPkg::dataWidth-1:0]     regData2,
    input  logic                            src1Busy,
    input  logic [rsPkg::robIndexWidth-1:0] src1Tag,
    input  logic                            src2Busy,
    input  logic [rsPkg::robIndexWidth-1:0] src2Tag,
    input  logic [rsPkg::condWidth-1:0]     cond,
    input  logic                            flagsReady,
    input  logic [rsPkg::robIndexWidth-1:0] flagsTag,
    input  logic                            aluResultValid,
    input  logic [rsPkg::robIndexWidth-1:0] aluResultTag,
    input  logic [rsPkg::dataWidth-1:0]     aluResult,
    input  logic                            memResultValid,
    input  logic [rsPkg::robIndexWidth-1:0] memResultTag,
    input  logic [rsPkg::dataWidth-1:0]     memResult,
    output logic [rsPkg::dataWidth-1:0]     srcAValue,
    output logic                            srcAPending,
    output logic [rsPkg::robIndexWidth-1:0] srcATag,
    output logic [rsPkg::dataWidth-1:0]     srcBValue,
    output logic                            srcBPending,
    output logic [rsPkg::robIndexWidth-1:0] srcBTag,
    output logic                            flagPending,
    output logic [rsPkg::robIndexWidth-1:0] flagTag
);
    import rsPkg::*;

    // Result is {pending, value}; the ALU lane wins over the memory lane.
    function automatic logic [dataWidth:0] resolve(
        input logic                     busy,
        input logic [robIndexWidth-1:0] tag,
        input logic [dataWidth-1:0]     regValue
    );
        logic [dataWidth:0] result;
        if (!busy) begin
            result = {1'b0, regValue};
        end else if (aluResultValid && aluResultTag == tag) begin
            result = {1'b0, aluResult};              // Forwarded in the issue cycle.
        end else if (memResultValid && memResultTag == tag) begin
            result = {1'b0, memResult};
        end else begin
            result = {1'b1, regValue};               // Value is filled in on wake-up.
        end
        return result;
    endfunction

    always_comb begin
        {srcAPending, srcAValue} = resolve(src1Busy, src1Tag, regData1);
        if (useImm) begin
            {srcBPending, srcBValue} = {1'b0, immediate};
        end else begin
            {srcBPending, srcBValue} = resolve(src2Busy, src2Tag, regData2);
        end
    end

    assign srcATag = src1Tag;
    assign srcBTag = src2Tag;
    assign flagPending = (cond != condAlways) && !flagsReady;
    assign flagTag = flagsTag;
endmodule

//--- hdl/rsPkg.sv
package rsPkg;
    localparam int dataWidth = 32;
    localparam int robIndexWidth = 3;         // Rename tags are reorder-buffer indices.
    localparam int opWidth = 5;
    localparam int condWidth = 4;
    localparam int flagWriteWidth = condWidth;
    localparam int shamtWidth = 5;
    localparam int shiftTypeWidth = 2;

    localparam logic [condWidth-1:0] condAlways = 4'hE;   // Such instructions never wait for flags.
endpackage
